// File: verilog/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch front end constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// First fetch address after reset
`define FE_RESET_PC 32'h1c000000

// Number of entries in the fully associative instruction TLB
`define FE_TLB_ENTRY_NUM 4

// BTB index bits taken from pc[5:2], so the table holds 16 entries
`define FE_BTB_IDX_W 4

// Exception codes reported in excp_pass_t
`define FE_ECODE_ALE  6'h09 // Misaligned fetch address
`define FE_ECODE_TLBR 6'h3f // No TLB entry matches
`define FE_ECODE_PIF  6'h03 // Matching page is not valid for fetch
`define FE_ECODE_PPI  6'h07 // Current privilege level is too low for the page

// Value carried in the ecode field when nothing is raised
`define FE_ECODE_NONE 6'h00

`endif

// File: verilog/fe_pkg.sv
`default_nettype none

package fe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Plain vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] u32_t;
    typedef logic [31:0] virt_t;  // Virtual address as seen by the PC
    typedef logic [31:0] phy_t;   // Physical address sent to the cache
    typedef logic [9:0]  asid_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [1:0]  plv_t;   // Zero is the most privileged level

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        MAT_SUC = 2'd0, // Strongly ordered and uncached
        MAT_CC  = 2'd1  // Coherent cached
    } mat_t;

    typedef enum logic [2:0] {
        IC_NOP = 3'd0,
        IC_RW  = 3'd1
    } ic_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grouped signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One instruction TLB entry mapping a single 4 KiB page
    typedef struct packed {
        logic        e;     // Entry exists
        asid_t       asid;
        logic        g;     // Global entries ignore the ASID
        logic [19:0] vppn;  // Compared against va[31:12]
        logic [19:0] ppn;
        logic        v;     // Page valid for access
        plv_t        plv;   // Lowest privilege allowed to fetch
        mat_t        mat;
    } itlb_entry_t;

    typedef struct packed {
        logic  da;    // Direct address translation
        plv_t  plv;
        asid_t asid;
        mat_t  datm;  // Memory type while in direct mode
    } fe_csr_t;

    // Redirect from execute, which also carries the resolved branch
    typedef struct packed {
        logic valid;
        u32_t pc;
        logic br_valid;
        u32_t br_pc;
        logic br_taken;
    } redirect_t;

    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    typedef struct packed {
        logic is_flush;
        u32_t pc;
        u32_t btb_pre; // Address chosen to follow pc
    } fetch_pass_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        virt_t  badv;
    } excp_pass_t;

endpackage

`default_nettype wire

// File: verilog/tlb_lookup.sv
`default_nettype none

`include "fe_consts.svh"

module tlb_lookup (
    input  fe_pkg::itlb_entry_t entries [`FE_TLB_ENTRY_NUM],
    input  fe_pkg::asid_t       asid,
    input  fe_pkg::plv_t        plv,
    input  fe_pkg::virt_t       va,
    output fe_pkg::phy_t        pa,
    output fe_pkg::mat_t        mat,
    output fe_pkg::ecode_t      ecode,
    output logic                is_exc
);
    import fe_pkg::*;

    logic [`FE_TLB_ENTRY_NUM-1:0] hit_vec;
    itlb_entry_t                  hit_entry;
    logic                         found;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Associative match
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < `FE_TLB_ENTRY_NUM; i++) begin
            hit_vec[i] = entries[i].e
                      && (entries[i].vppn == va[31:12])
                      && (entries[i].g || (entries[i].asid == asid));
        end
    end

    assign found = |hit_vec;

    // Software keeps entries unique, so the lowest index simply wins any overlap
    always_comb begin
        hit_entry = '0;
        for (int i = `FE_TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_entry = entries[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Translation result and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pa  = {hit_entry.ppn, va[11:0]}; // Page offset passes straight through
    assign mat = hit_entry.mat;

    always_comb begin
        is_exc = 1'b1;
        ecode  = `FE_ECODE_NONE;
        if (!found) begin
            ecode = `FE_ECODE_TLBR;
        end else if (!hit_entry.v) begin
            ecode = `FE_ECODE_PIF;
        end else if (plv > hit_entry.plv) begin
            ecode = `FE_ECODE_PPI;  // Larger plv means less privilege
        end else begin
            is_exc = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_target_buffer.sv
`default_nettype none

`include "fe_consts.svh"

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fe_pkg::u32_t         btb_pc,
    input  logic                 btb_is_stall,
    input  fe_pkg::redirect_t    redirect,
    output fe_pkg::btb_predict_t btb_predict
);
    import fe_pkg::*;

    localparam int IDX_W = `FE_BTB_IDX_W;
    localparam int DEPTH = 1 << IDX_W;
    localparam int TAG_W = 32 - IDX_W - 2;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    logic [DEPTH-1:0] entry_valid;
    btb_tag_t         entry_tag [DEPTH];
    u32_t             entry_target [DEPTH];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    logic     rd_hit;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_tag_match;

    logic     pred_valid;
    u32_t     pred_npc;

    assign rd_idx = btb_pc[IDX_W+1:2];
    assign rd_tag = btb_pc[31:IDX_W+2];
    assign rd_hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);

    assign wr_idx       = redirect.br_pc[IDX_W+1:2];
    assign wr_tag       = redirect.br_pc[31:IDX_W+2];
    assign wr_tag_match = (entry_tag[wr_idx] == wr_tag);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Training from resolved branches
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (redirect.br_valid) begin
            if (redirect.br_taken) begin
                entry_valid[wr_idx] <= 1'b1;
            end else if (wr_tag_match) begin
                entry_valid[wr_idx] <= 1'b0; // Only drop the entry that belongs to this branch
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.br_valid && redirect.br_taken) begin
            entry_tag[wr_idx]    <= wr_tag;
            entry_target[wr_idx] <= redirect.pc; // Redirect target is the resolved destination
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The lookup samples the tables before this edge's write lands
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else if (!btb_is_stall) begin
            pred_valid <= rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!btb_is_stall) begin
            pred_npc <= entry_target[rd_idx];
        end
    end

    assign btb_predict = '{valid: pred_valid, npc: pred_npc};

endmodule

`default_nettype wire

// File: verilog/fetch_pc_stage.sv
`default_nettype none

`include "fe_consts.svh"

module fetch_pc_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fe_pkg::redirect_t    redirect,
    input  fe_pkg::btb_predict_t btb_predict,
    output fe_pkg::u32_t         btb_pc,
    output logic                 btb_is_stall,
    input  fe_pkg::fe_csr_t      csr,
    input  fe_pkg::itlb_entry_t  itlb_entries [`FE_TLB_ENTRY_NUM],
    input  logic                 is_stall,
    input  logic                 is_flush,
    output logic [11:0]          icache_idx,
    output fe_pkg::ic_op_t       icache_op,
    output fe_pkg::phy_t         icache_pa,
    output logic                 icache_is_cached,
    output fe_pkg::fetch_pass_t  pass_out,
    output fe_pkg::excp_pass_t   excp_pass_out
);
    import fe_pkg::*;

    u32_t   pc;
    u32_t   npc;

    phy_t   tlb_pa;
    mat_t   tlb_mat;
    ecode_t tlb_ecode;
    logic   tlb_is_exc;

    logic   is_tlb;
    mat_t   fetch_mat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next PC and PC register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A prediction here was looked up for the current pc in the previous cycle
    always_comb begin
        if (redirect.valid) begin
            npc = redirect.pc;
        end else if (btb_predict.valid) begin
            npc = btb_predict.npc;
        end else begin
            npc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc <= `FE_RESET_PC;
        end else if (!is_stall) begin
            pc <= npc;
        end
    end

    // The BTB reads npc so its result lines up with the pc register
    assign btb_pc       = npc;
    assign btb_is_stall = is_stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address translation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tlb_lookup u_tlb_lookup (
        .entries (itlb_entries),
        .asid    (csr.asid),
        .plv     (csr.plv),
        .va      (pc),
        .pa      (tlb_pa),
        .mat     (tlb_mat),
        .ecode   (tlb_ecode),
        .is_exc  (tlb_is_exc)
    );

    assign is_tlb    = !csr.da;
    assign fetch_mat = is_tlb ? tlb_mat : csr.datm;

    assign icache_idx       = pc[11:0]; // Index bits are the same in both address spaces
    assign icache_pa        = is_tlb ? tlb_pa : pc;
    assign icache_is_cached = (fetch_mat == MAT_CC);
    assign icache_op        = is_flush ? IC_NOP : IC_RW;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exceptions and pass to the next stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        excp_pass_out.valid = 1'b0;
        excp_pass_out.ecode = tlb_ecode;
        excp_pass_out.badv  = pc;
        if (pc[1:0] != 2'b00) begin
            excp_pass_out.valid = 1'b1;
            excp_pass_out.ecode = `FE_ECODE_ALE; // Alignment outranks any TLB fault
        end else if (is_tlb && tlb_is_exc) begin
            excp_pass_out.valid = 1'b1;
        end
    end

    assign pass_out = '{is_flush: is_flush, pc: pc, btb_pre: npc};

endmodule

`default_nettype wire

// File: verilog/fetch_front_end.sv
`default_nettype none

`include "fe_consts.svh"

module fetch_front_end (
    input  logic                clk,
    input  logic                rst_n,

    // Control and state from the rest of the core
    input  fe_pkg::redirect_t   redirect,
    input  fe_pkg::fe_csr_t     csr,
    input  fe_pkg::itlb_entry_t itlb_entries [`FE_TLB_ENTRY_NUM],
    input  logic                is_stall,
    input  logic                is_flush,

    // Instruction cache request
    output logic [11:0]         icache_idx,
    output fe_pkg::ic_op_t      icache_op,
    output fe_pkg::phy_t        icache_pa,
    output logic                icache_is_cached,

    // Toward the next stage
    output fe_pkg::fetch_pass_t pass_out,
    output fe_pkg::excp_pass_t  excp_pass_out
);
    import fe_pkg::*;

    u32_t         btb_pc;
    logic         btb_is_stall;
    btb_predict_t btb_predict;

    fetch_pc_stage u_fetch_pc_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .redirect         (redirect),
        .btb_predict      (btb_predict),
        .btb_pc           (btb_pc),
        .btb_is_stall     (btb_is_stall),
        .csr              (csr),
        .itlb_entries     (itlb_entries),
        .is_stall         (is_stall),
        .is_flush         (is_flush),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .pass_out         (pass_out),
        .excp_pass_out    (excp_pass_out)
    );

    // Trained by the same redirect that steers the PC
    branch_target_buffer u_branch_target_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .btb_pc       (btb_pc),
        .btb_is_stall (btb_is_stall),
        .redirect     (redirect),
        .btb_predict  (btb_predict)
    );

endmodule

`default_nettype wire

// File: tests/fetch_asserts.sv
`default_nettype none

module fetch_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               is_stall,
    input fe_pkg::redirect_t  redirect,
    input fe_pkg::u32_t       pc,
    input fe_pkg::excp_pass_t excp_pass_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // Read by the testbench at the end of the run

    // A stalled stage keeps its fetch address
    pc_holds_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        is_stall |=> (pc == $past(pc)))
    else begin
        fail_count++;
        $error("pc changed while the stage was stalled");
    end

    redirect_steers_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect.valid && !is_stall) |=> (pc == $past(redirect.pc)))
    else begin
        fail_count++;
        $error("pc did not follow the redirect target");
    end

    misaligned_raises_exc: assert property (@(posedge clk) disable iff (!rst_n)
        (pc[1:0] != 2'b00) |-> excp_pass_out.valid)
    else begin
        fail_count++;
        $error("misaligned pc without an exception");
    end

endmodule

bind fetch_pc_stage fetch_asserts u_fetch_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .is_stall      (is_stall),
    .redirect      (redirect),
    .pc            (pc),
    .excp_pass_out (excp_pass_out)
);

`default_nettype wire

// File: tests/fetch_checker.sv
`default_nettype none

`include "fe_consts.svh"

module fetch_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  fe_pkg::redirect_t   redirect,
    input  fe_pkg::fe_csr_t     csr,
    input  fe_pkg::itlb_entry_t itlb_entries [`FE_TLB_ENTRY_NUM],
    input  logic                is_stall,
    input  logic                is_flush,
    input  logic [11:0]         icache_idx,
    input  fe_pkg::ic_op_t      icache_op,
    input  fe_pkg::phy_t        icache_pa,
    input  logic                icache_is_cached,
    input  fe_pkg::fetch_pass_t pass_out,
    input  fe_pkg::excp_pass_t  excp_pass_out,
    input  logic                exp_valid,
    input  fe_pkg::u32_t        exp_pc,
    output int                  model_errors,
    output int                  vector_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    import fe_pkg::*;

    typedef struct packed {
        logic   exc;
        ecode_t ecode;
        logic   cached;
        phy_t   pa;
    } xlate_t;

    u32_t         pc_q;        // Expected fetch pc
    btb_predict_t pred_q;      // Expected registered BTB read
    logic [15:0]  btb_v;
    logic [25:0]  btb_tag [16];
    u32_t         btb_tgt [16];
    xlate_t       xl;
    u32_t         npc;
    logic         exc;
    ecode_t       ecode;
    logic [3:0]   idx;

    initial begin
        model_errors  = 0;
        vector_errors = 0;
    end

    // Direct mode passes the address through, TLB mode takes the first matching entry
    function automatic xlate_t translate(input u32_t va);
        xlate_t r;
        logic   hit;
        r   = '{exc: 1'b1, ecode: `FE_ECODE_TLBR, cached: 1'b0, pa: '0};
        hit = 1'b0;
        if (csr.da) begin
            r = '{exc: 1'b0, ecode: `FE_ECODE_NONE, cached: (csr.datm == MAT_CC), pa: va};
        end else begin
            for (int i = 0; i < `FE_TLB_ENTRY_NUM; i++) begin
                if (!hit && itlb_entries[i].e && (itlb_entries[i].vppn == va[31:12])
                        && (itlb_entries[i].g || (itlb_entries[i].asid == csr.asid))) begin
                    hit      = 1'b1;
                    r.pa     = {itlb_entries[i].ppn, va[11:0]};
                    r.cached = (itlb_entries[i].mat == MAT_CC);
                    if (!itlb_entries[i].v) begin
                        r.ecode = `FE_ECODE_PIF;
                    end else if (csr.plv > itlb_entries[i].plv) begin
                        r.ecode = `FE_ECODE_PPI;
                    end else begin
                        r.exc = 1'b0;
                    end
                end
            end
        end
        return r;
    endfunction

    task automatic check(input logic ok, input string what);
        if (!ok) begin
            $display("[FAIL] %0t: %s at pc %h", $time, what, pc_q);
            model_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare at each rising edge, then advance the model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q   = `FE_RESET_PC;
            pred_q = '0;
            btb_v  = '0;
        end else begin
            xl    = translate(pc_q);
            npc   = redirect.valid ? redirect.pc : (pred_q.valid ? pred_q.npc : pc_q + 32'd4);
            exc   = (pc_q[1:0] != 2'b00) || xl.exc;
            ecode = (pc_q[1:0] != 2'b00) ? `FE_ECODE_ALE : xl.ecode;
            if (exp_valid && (pass_out.pc !== exp_pc)) begin
                $display("[FAIL] %0t: fetch pc %h, vector expects %h", $time, pass_out.pc, exp_pc);
                vector_errors++;
            end
            check(pass_out.pc === pc_q, $sformatf("fetch pc is %h", pass_out.pc));
            check(pass_out.btb_pre === npc, $sformatf("btb_pre %h, expected %h",
                  pass_out.btb_pre, npc));
            check(pass_out.is_flush === is_flush, "is_flush not passed on");
            check(icache_op === (is_flush ? IC_NOP : IC_RW), "wrong icache_op");
            check(icache_idx === pc_q[11:0], "wrong icache_idx");
            if (!xl.exc) begin
                check(icache_pa === xl.pa, $sformatf("icache_pa %h, expected %h", icache_pa, xl.pa));
                check(icache_is_cached === xl.cached, "wrong cacheability");
            end
            check(excp_pass_out.valid === exc, "wrong exception valid");
            if (exc) begin
                check(excp_pass_out.ecode === ecode, $sformatf("ecode %h, expected %h",
                      excp_pass_out.ecode, ecode));
                check(excp_pass_out.badv === pc_q, "badv differs from pc");
            end

            if (!is_stall) begin
                pred_q.valid = btb_v[npc[5:2]] && (btb_tag[npc[5:2]] == npc[31:6]);
                pred_q.npc   = btb_tgt[npc[5:2]]; // Read before this edge's training
                pc_q         = npc;
            end
            if (redirect.br_valid) begin
                idx = redirect.br_pc[5:2];
                if (redirect.br_taken) begin
                    btb_v[idx]   = 1'b1;
                    btb_tag[idx] = redirect.br_pc[31:6];
                    btb_tgt[idx] = redirect.pc;
                end else if (btb_tag[idx] == redirect.br_pc[31:6]) begin
                    btb_v[idx] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/fetch_front_end_tb.sv
`default_nettype none

`include "fe_consts.svh"

module fetch_front_end_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fe_pkg::*;

    localparam int MAX_VEC = 64;

    // One cycle of stimulus as read from the vector file
    typedef struct packed {
        logic stall;
        logic flush;
        logic da;
        plv_t plv;
        logic datm;
        logic rv;
        u32_t rpc;
        logic bv;
        u32_t bpc;
        logic bt;
        u32_t exp_pc;
    } vec_t;

    logic        clk;
    logic        rst_n;
    redirect_t   redirect;
    fe_csr_t     csr;
    itlb_entry_t itlb_entries [`FE_TLB_ENTRY_NUM];
    logic        is_stall;
    logic        is_flush;
    logic [11:0] icache_idx;
    ic_op_t      icache_op;
    phy_t        icache_pa;
    logic        icache_is_cached;
    fetch_pass_t pass_out;
    excp_pass_t  excp_pass_out;
    logic        exp_valid;
    u32_t        exp_pc;
    int          model_errors;
    int          vector_errors;

    vec_t        vecs [MAX_VEC];
    int          gaps [MAX_VEC];
    vec_t        idle;
    int          n_vec;
    int          n_tlb;
    int          limit = 0;
    int          cycles = 0;
    int          other_errors = 0;
    int unsigned seed;
    logic        read_ok;

    fetch_front_end u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .redirect         (redirect),
        .csr              (csr),
        .itlb_entries     (itlb_entries),
        .is_stall         (is_stall),
        .is_flush         (is_flush),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .pass_out         (pass_out),
        .excp_pass_out    (excp_pass_out)
    );

    fetch_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .redirect         (redirect),
        .csr              (csr),
        .itlb_entries     (itlb_entries),
        .is_stall         (is_stall),
        .is_flush         (is_flush),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .pass_out         (pass_out),
        .excp_pass_out    (excp_pass_out),
        .exp_valid        (exp_valid),
        .exp_pc           (exp_pc),
        .model_errors     (model_errors),
        .vector_errors    (vector_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector file and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_vectors(output logic ok);
        int            fd;
        int            code;
        logic          bad;
        logic [63:0]   tag;
        logic [1023:0] rest;
        u32_t          f [11];
        n_vec = 0;
        n_tlb = 0;
        bad   = 1'b0;
        fd    = $fopen("tests/fetch_vectors.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "T" && n_tlb < `FE_TLB_ENTRY_NUM) begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    bad  = bad || (code != 8);
                    itlb_entries[n_tlb] = '{e: f[0][0], asid: f[1][9:0], g: f[2][0],
                                            vppn: f[3][19:0], ppn: f[4][19:0], v: f[5][0],
                                            plv: f[6][1:0], mat: mat_t'(f[7][1:0])};
                    n_tlb++;
                end else if (tag == "C" && n_vec < MAX_VEC) begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                   f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    bad  = bad || (code != 11);
                    vecs[n_vec] = '{stall: f[0][0], flush: f[1][0], da: f[2][0],
                                    plv: f[3][1:0], datm: f[4][0], rv: f[5][0], rpc: f[6],
                                    bv: f[7][0], bpc: f[8], bt: f[9][0], exp_pc: f[10]};
                    n_vec++;
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && !bad && (n_tlb == `FE_TLB_ENTRY_NUM) && (n_vec > 0);
    endtask

    task automatic drive(input vec_t v, input logic check_pc);
        is_stall  = v.stall;
        is_flush  = v.flush;
        csr.da    = v.da;
        csr.plv   = v.plv;
        csr.datm  = v.datm ? MAT_CC : MAT_SUC;
        redirect  = '{valid: v.rv, pc: v.rpc, br_valid: v.bv, br_pc: v.bpc, br_taken: v.bt};
        exp_valid = check_pc;
        exp_pc    = v.exp_pc;
    endtask

    task automatic end_run();
        int assert_errors;
        assert_errors = u_dut.u_fetch_pc_stage.u_fetch_asserts.fail_count;
        $display("Errors: %0d model, %0d vector, %0d assertion, %0d other",
                 model_errors, vector_errors, assert_errors, other_errors);
        if (model_errors + vector_errors + assert_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        rst_n     = 1'b0;
        is_stall  = 1'b0;
        is_flush  = 1'b0;
        redirect  = '0;
        csr       = '{da: 1'b1, plv: 2'd0, asid: 10'h005, datm: MAT_CC};
        exp_valid = 1'b0;
        exp_pc    = '0;
        for (int i = 0; i < `FE_TLB_ENTRY_NUM; i++) begin
            itlb_entries[i] = '0;
        end
        seed = 32'h932c6706;
        void'($urandom(seed));

        read_vectors(read_ok);
        if (!read_ok) begin
            $display("Could not read a complete tests/fetch_vectors.txt");
            other_errors++;
        end else begin
            limit = n_vec + 2 + 20;
            for (int i = 0; i < n_vec; i++) begin
                gaps[i] = $urandom % 3; // Stalled idle cycles in which the pc must hold
                limit  += gaps[i];
            end
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_vec; i++) begin
                drive(vecs[i], 1'b1);
                @(negedge clk);
                idle       = vecs[i];
                idle.stall = 1'b1;
                idle.flush = 1'b0;
                idle.rv    = 1'b0;
                idle.bv    = 1'b0;
                for (int g = 0; g < gaps[i]; g++) begin
                    drive(idle, 1'b0);
                    @(negedge clk);
                end
            end
        end
        end_run();
    end

    // Watchdog on the cycle count
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            other_errors++;
            end_run();
        end
    end

endmodule

`default_nettype wire

// File: tests/fetch_vectors.txt
# T e asid g vppn ppn v plv mat
# C stall flush da plv datm redir_valid redir_pc br_valid br_pc br_taken expected_pc
T 1 005 0 1c000 00100 1 3 1
T 1 000 1 1c001 00200 0 3 0
T 1 000 1 1c002 00300 1 0 0
T 1 007 0 1c003 00400 1 3 1
C 0 0 1 0 1 0 00000000 0 00000000 0 1c000000
C 0 1 1 0 0 0 00000000 0 00000000 0 1c000004
C 1 0 1 0 1 0 00000000 0 00000000 0 1c000008
C 0 0 1 0 1 1 1c000040 1 1c000008 1 1c000008
C 0 0 1 0 1 1 1c000004 0 00000000 0 1c000040
C 0 0 1 0 1 0 00000000 0 00000000 0 1c000004
C 0 0 1 0 1 0 00000000 0 00000000 0 1c000008
C 0 0 1 0 1 1 1c000004 1 1c000008 0 1c000040
C 0 0 1 0 1 0 00000000 0 00000000 0 1c000004
C 0 0 0 0 1 0 00000000 0 00000000 0 1c000008
C 0 0 0 0 1 1 1c001000 0 00000000 0 1c00000c
C 0 0 0 0 1 1 1c002000 0 00000000 0 1c001000
C 0 0 0 0 1 0 00000000 0 00000000 0 1c002000
C 0 0 0 3 1 1 1c003000 0 00000000 0 1c002004
C 0 0 0 0 1 1 1c000022 0 00000000 0 1c003000
C 0 0 0 0 1 1 1c003002 0 00000000 0 1c000022
C 0 0 0 0 1 1 1c001000 0 00000000 0 1c003002
C 0 1 1 0 1 0 00000000 0 00000000 0 1c001000
C 0 0 1 0 1 0 00000000 0 00000000 0 1c001004

// File: flist.f
+incdir+verilog
verilog/fe_pkg.sv
verilog/tlb_lookup.sv
verilog/branch_target_buffer.sv
verilog/fetch_pc_stage.sv
verilog/fetch_front_end.sv
tests/fetch_asserts.sv
tests/fetch_checker.sv
tests/fetch_front_end_tb.sv
